// File: common/pg_settings.svh
`ifndef PG_SETTINGS_SVH
`define PG_SETTINGS_SVH

// Phase circle
`define PG_PHASE_BITS      10
`define PG_OCTANT_BITS     3
`define PG_OCTANT_SPAN     128

// Twiddle table covering one eighth of the circle
`define PG_TABLE_DEPTH     136
`define PG_TABLE_ADDR_BITS 8
`define PG_COMP_BITS       32

// Step entry store
`define PG_ENTRY_COUNT     64
`define PG_ENTRY_BITS      6

// Host bus map in word addresses
`define PG_WB_ADDR_BITS    10
`define PG_WB_DATA_BITS    32
`define PG_TABLE_WORDS     (2 * `PG_TABLE_DEPTH)
`define PG_ENTRY_BASE      512

// Stages from accumulator input to twiddle output
`define PG_DRAIN_CYCLES    4

`endif

// File: common/pg_stream_pkg.sv
`include "pg_settings.svh"

package pg_stream_pkg;

  ////////////////////////////////////////////////////////////
  // Stream pipeline types
  ////////////////////////////////////////////////////////////

  // Accumulator output
  typedef struct packed {
    logic                      valid;
    logic [`PG_PHASE_BITS-1:0] phase;
  } phase_t;

  // Folder output with the octant next to the table address
  typedef struct packed {
    logic                           valid;
    logic [`PG_OCTANT_BITS-1:0]     octant;
    logic [`PG_TABLE_ADDR_BITS-1:0] addr;
  } fold_t;

  // One complex table word or output twiddle
  typedef struct packed {
    logic signed [`PG_COMP_BITS-1:0] re;
    logic signed [`PG_COMP_BITS-1:0] im;
  } twiddle_t;

endpackage

// File: common/pg_bus_pkg.sv
`include "pg_settings.svh"

package pg_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Wishbone classic
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [`PG_WB_ADDR_BITS-1:0] adr;
    logic [`PG_WB_DATA_BITS-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                        ack;
    logic [`PG_WB_DATA_BITS-1:0] dat;
  } wb_rsp_t;

  ////////////////////////////////////////////////////////////
  // Configuration words
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [5:0]                pad_hi;
    logic [`PG_PHASE_BITS-1:0] start;
    logic [5:0]                pad_lo;
    logic [`PG_PHASE_BITS-1:0] step;
  } step_entry_t;

  // Write word seen as a table component or as a step entry
  typedef union packed {
    logic [`PG_WB_DATA_BITS-1:0] raw;
    step_entry_t                 entry;
  } cfg_word_u;

  // Table access from the bus side
  typedef struct packed {
    logic                           valid;
    logic                           we;
    logic [`PG_TABLE_ADDR_BITS-1:0] entry;
    logic                           comp;
    logic [`PG_COMP_BITS-1:0]       data;
  } pg_host_req_t;

endpackage

// File: rtl/pg_wb_slave.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module pg_wb_slave
  import pg_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  wb_req_t                   i_wb,
  output wb_rsp_t                   o_wb,
  input  logic [`PG_ENTRY_BITS-1:0] i_entry_select,
  output step_entry_t               o_entry,
  output pg_host_req_t              o_host_req,
  input  logic                      i_host_grant,
  input  logic [`PG_COMP_BITS-1:0]  i_host_rdata
);

  typedef enum logic [1:0] {ST_IDLE, ST_TABLE, ST_ACK} state_t;

  state_t                         state;
  step_entry_t                    entries [`PG_ENTRY_COUNT];
  cfg_word_u                      wr_word;
  logic                           accept;
  logic                           table_hit;
  logic                           entry_hit;
  logic [`PG_ENTRY_BITS-1:0]      entry_idx;
  logic                           ack_q;
  logic [`PG_WB_DATA_BITS-1:0]    rdata_q;
  logic                           req_valid;
  logic                           req_we;
  logic [`PG_TABLE_ADDR_BITS-1:0] req_entry;
  logic                           req_comp;
  logic [`PG_COMP_BITS-1:0]       req_data;

  assign accept    = (state == ST_IDLE) && i_wb.cyc && i_wb.stb;
  assign table_hit = 32'(i_wb.adr) < `PG_TABLE_WORDS;
  assign entry_hit = (32'(i_wb.adr) >= `PG_ENTRY_BASE) &&
                     (32'(i_wb.adr) < (`PG_ENTRY_BASE + `PG_ENTRY_COUNT));
  assign entry_idx = i_wb.adr[`PG_ENTRY_BITS-1:0];
  assign wr_word.raw = i_wb.dat;

  ////////////////////////////////////////////////////////////
  // Bus cycle control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      ack_q     <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept && table_hit) begin
            req_valid <= 1'b1;
            state     <= ST_TABLE;
          end else if (accept) begin
            ack_q <= 1'b1;
            state <= ST_ACK;
          end
        end
        ST_TABLE: begin
          // Held until the table RAM finds a free slot
          if (i_host_grant) begin
            req_valid <= 1'b0;
            ack_q     <= 1'b1;
            state     <= ST_ACK;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_we    <= i_wb.we;
      req_entry <= i_wb.adr[`PG_TABLE_ADDR_BITS:1];
      req_comp  <= i_wb.adr[0];
      req_data  <= wr_word.raw;
      rdata_q   <= entry_hit ? entries[entry_idx] : '0;
    end else if (state == ST_TABLE && i_host_grant) begin
      rdata_q <= i_host_rdata;
    end
  end

  // Step entry store
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PG_ENTRY_COUNT; i++) begin
        entries[i] <= '0;
      end
    end else if (accept && entry_hit && i_wb.we) begin
      entries[entry_idx] <= '{pad_hi: '0, start: wr_word.entry.start,
                              pad_lo: '0, step: wr_word.entry.step};
    end
  end

  assign o_entry    = entries[i_entry_select];
  assign o_wb       = '{ack: ack_q, dat: rdata_q};
  assign o_host_req = '{valid: req_valid, we: req_we, entry: req_entry,
                        comp: req_comp, data: req_data};

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack_q |-> (i_wb.cyc && i_wb.stb));

endmodule

// File: phase_gen/pg_phase_accum.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module pg_phase_accum
  import pg_stream_pkg::*;
  import pg_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_start,
  input  logic        i_valid,
  input  logic        i_last,
  input  step_entry_t i_entry,
  output phase_t      o_phase,
  output logic        o_busy
);

  logic [`PG_PHASE_BITS-1:0] phase_q;
  logic [`PG_PHASE_BITS-1:0] start_q;
  logic [`PG_PHASE_BITS-1:0] step_q;
  logic                      running;
  logic [2:0]                drain_cnt;
  phase_t                    out_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q   <= '0;
      start_q   <= '0;
      step_q    <= '0;
      running   <= 1'b0;
      drain_cnt <= '0;
      out_q     <= '0;
    end else begin
      out_q <= '{valid: i_valid, phase: phase_q};
      if (i_start) begin
        start_q <= i_entry.start;
        step_q  <= i_entry.step;
        phase_q <= i_entry.start;
        running <= 1'b1;
      end else if (i_valid && i_last) begin
        phase_q <= start_q;
        running <= 1'b0;
      end else if (i_valid) begin
        // Wraps on the 1024-point circle
        phase_q <= phase_q + step_q;
        running <= 1'b1;
      end
      if (i_valid && i_last) begin
        drain_cnt <= 3'(`PG_DRAIN_CYCLES);
      end else if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 3'd1;
      end
    end
  end

  assign o_phase = out_q;
  assign o_busy  = running || (drain_cnt != '0);

  a_start_not_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_start && i_valid));

endmodule

// File: phase_gen/pg_octant_fold.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module pg_octant_fold
  import pg_stream_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  phase_t i_phase,
  output fold_t  o_fold
);

  localparam int OFS_BITS = `PG_PHASE_BITS - `PG_OCTANT_BITS;

  logic [`PG_OCTANT_BITS-1:0]     octant;
  logic [OFS_BITS-1:0]            offset;
  logic [`PG_TABLE_ADDR_BITS-1:0] addr;
  logic                           valid_q;
  logic [`PG_OCTANT_BITS-1:0]     octant_q;
  logic [`PG_TABLE_ADDR_BITS-1:0] addr_q;

  assign octant = i_phase.phase[`PG_PHASE_BITS-1 -: `PG_OCTANT_BITS];
  assign offset = i_phase.phase[OFS_BITS-1:0];

  ////////////////////////////////////////////////////////////
  // Fold into 0..128
  ////////////////////////////////////////////////////////////

  // Even octants use a = p - 128*o
  // Odd octants reflect from the next boundary as a = 128*(o+1) - p
  always_comb begin
    if (octant[0]) begin
      addr = `PG_TABLE_ADDR_BITS'(`PG_OCTANT_SPAN) - {1'b0, offset};
    end else begin
      addr = {1'b0, offset};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_phase.valid;
    end
  end

  always_ff @(posedge clk) begin
    octant_q <= octant;
    addr_q   <= addr;
  end

  assign o_fold = '{valid: valid_q, octant: octant_q, addr: addr_q};

endmodule

// File: phase_gen/pg_twiddle_ram.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module pg_twiddle_ram
  import pg_stream_pkg::*;
  import pg_bus_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  fold_t                      i_fold,
  input  logic                       i_busy,
  input  pg_host_req_t               i_host_req,
  output logic                       o_host_grant,
  output logic [`PG_COMP_BITS-1:0]   o_host_rdata,
  output twiddle_t                   o_word,
  output logic [`PG_OCTANT_BITS-1:0] o_octant,
  output logic                       o_valid
);

  twiddle_t                   mem [`PG_TABLE_DEPTH];
  logic                       host_go;
  logic                       grant_q;
  logic                       valid_q;
  twiddle_t                   word_q;
  logic [`PG_OCTANT_BITS-1:0] octant_q;
  logic [`PG_COMP_BITS-1:0]   rdata_q;

  // Host only gets the port between streams and never back to back
  assign host_go = i_host_req.valid && !grant_q && !i_busy && !i_fold.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      grant_q <= host_go;
      valid_q <= i_fold.valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Single port array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_fold.valid) begin
      word_q   <= mem[i_fold.addr];
      octant_q <= i_fold.octant;
    end else if (host_go) begin
      if (i_host_req.we && i_host_req.comp) begin
        mem[i_host_req.entry].im <= i_host_req.data;
      end else if (i_host_req.we) begin
        mem[i_host_req.entry].re <= i_host_req.data;
      end
      rdata_q <= i_host_req.comp ? mem[i_host_req.entry].im : mem[i_host_req.entry].re;
    end
  end

  assign o_host_grant = grant_q;
  assign o_host_rdata = rdata_q;
  assign o_word       = word_q;
  assign o_octant     = octant_q;
  assign o_valid      = valid_q;

  // Busy flag covers every stream read
  a_read_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    i_fold.valid |-> i_busy);

endmodule

// File: phase_gen/pg_octant_unfold.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module pg_octant_unfold
  import pg_stream_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  twiddle_t                   i_word,
  input  logic [`PG_OCTANT_BITS-1:0] i_octant,
  input  logic                       i_valid,
  output twiddle_t                   o_twiddle,
  output logic                       o_valid
);

  logic signed [`PG_COMP_BITS-1:0] cos_c;
  logic signed [`PG_COMP_BITS-1:0] sin_c;
  twiddle_t                        unfold;
  twiddle_t                        twiddle_q;
  logic                            valid_q;

  assign cos_c = i_word.re;
  assign sin_c = i_word.im;

  ////////////////////////////////////////////////////////////
  // Swap and negate per octant
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (i_octant)
      3'd0:    unfold = '{re: cos_c,  im: -sin_c};
      3'd1:    unfold = '{re: sin_c,  im: -cos_c};
      3'd2:    unfold = '{re: -sin_c, im: -cos_c};
      3'd3:    unfold = '{re: -cos_c, im: -sin_c};
      3'd4:    unfold = '{re: -cos_c, im: sin_c};
      3'd5:    unfold = '{re: -sin_c, im: cos_c};
      3'd6:    unfold = '{re: sin_c,  im: cos_c};
      default: unfold = '{re: cos_c,  im: sin_c};
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  // Holds the last twiddle between samples
  always_ff @(posedge clk) begin
    if (i_valid) begin
      twiddle_q <= unfold;
    end
  end

  assign o_twiddle = twiddle_q;
  assign o_valid   = valid_q;

endmodule

// File: rtl/pg_top.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module pg_top
  import pg_stream_pkg::*;
  import pg_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  wb_req_t                   i_wb,
  output wb_rsp_t                   o_wb,
  input  logic                      i_start,
  input  logic [`PG_ENTRY_BITS-1:0] i_entry_select,
  input  logic                      i_valid,
  input  logic                      i_last,
  output twiddle_t                  o_twiddle,
  output logic                      o_valid
);

  step_entry_t                entry;
  pg_host_req_t               host_req;
  logic                       host_grant;
  logic [`PG_COMP_BITS-1:0]   host_rdata;
  phase_t                     phase;
  logic                       busy;
  fold_t                      fold;
  twiddle_t                   ram_word;
  logic [`PG_OCTANT_BITS-1:0] ram_octant;
  logic                       ram_valid;

  pg_wb_slave u_wb_slave (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_wb           (i_wb),
    .o_wb           (o_wb),
    .i_entry_select (i_entry_select),
    .o_entry        (entry),
    .o_host_req     (host_req),
    .i_host_grant   (host_grant),
    .i_host_rdata   (host_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Stream pipeline, one clock per stage
  ////////////////////////////////////////////////////////////

  pg_phase_accum u_phase_accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_start (i_start),
    .i_valid (i_valid),
    .i_last  (i_last),
    .i_entry (entry),
    .o_phase (phase),
    .o_busy  (busy)
  );

  pg_octant_fold u_octant_fold (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_phase (phase),
    .o_fold  (fold)
  );

  pg_twiddle_ram u_twiddle_ram (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_fold       (fold),
    .i_busy       (busy),
    .i_host_req   (host_req),
    .o_host_grant (host_grant),
    .o_host_rdata (host_rdata),
    .o_word       (ram_word),
    .o_octant     (ram_octant),
    .o_valid      (ram_valid)
  );

  pg_octant_unfold u_octant_unfold (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_word    (ram_word),
    .i_octant  (ram_octant),
    .i_valid   (ram_valid),
    .o_twiddle (o_twiddle),
    .o_valid   (o_valid)
  );

endmodule

// File: verif/tb_pg_top.sv
`timescale 1ns/1ps
`include "pg_settings.svh"

module tb_pg_top
  import pg_stream_pkg::*;
  import pg_bus_pkg::*;
();

  logic                      clk;
  logic                      rst_n;
  wb_req_t                   wb_req;
  wb_rsp_t                   wb_rsp;
  logic                      i_start;
  logic [`PG_ENTRY_BITS-1:0] entry_sel;
  logic                      i_valid;
  logic                      i_last;
  twiddle_t                  twiddle;
  logic                      o_valid;

  // Scoreboard and bus state of the main process
  twiddle_t                  exp_q [$];
  int                        cyc_q [$];
  string                     name_q [$];
  int                        cycle;
  int                        errors;
  int                        checks;
  logic                      aborted;
  logic                      bus_busy;
  logic                      ack_hold;
  logic [31:0]               bus_rdata;
  logic                      started;
  logic                      last_sent;
  logic [31:0]               sh_re [`PG_TABLE_DEPTH];
  logic [31:0]               sh_im [`PG_TABLE_DEPTH];
  logic [`PG_PHASE_BITS-1:0] sh_start [`PG_ENTRY_COUNT];
  logic [`PG_PHASE_BITS-1:0] sh_step [`PG_ENTRY_COUNT];

  pg_top u_pg_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_wb           (wb_req),
    .o_wb           (wb_rsp),
    .i_start        (i_start),
    .i_entry_select (entry_sel),
    .i_valid        (i_valid),
    .i_last         (i_last),
    .o_twiddle      (twiddle),
    .o_valid        (o_valid)
  );

  always #5 clk = ~clk;

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  // Octant rule applied to the shadow table
  function automatic twiddle_t octant_rule(input logic [`PG_PHASE_BITS-1:0] p);
    int          pi;
    logic [7:0]  a;
    logic [31:0] c;
    logic [31:0] s;
    twiddle_t    w;
    pi = int'(p);
    case (p[9:7])
      3'd0:    a = 8'(pi);
      3'd1:    a = 8'(256 - pi);
      3'd2:    a = 8'(pi - 256);
      3'd3:    a = 8'(512 - pi);
      3'd4:    a = 8'(pi - 512);
      3'd5:    a = 8'(768 - pi);
      3'd6:    a = 8'(pi - 768);
      default: a = 8'(1024 - pi);
    endcase
    c = sh_re[a];
    s = sh_im[a];
    case (p[9:7])
      3'd0:    w = '{re: c, im: -s};
      3'd1:    w = '{re: s, im: -c};
      3'd2:    w = '{re: -s, im: -c};
      3'd3:    w = '{re: -c, im: -s};
      3'd4:    w = '{re: -c, im: s};
      3'd5:    w = '{re: -s, im: c};
      3'd6:    w = '{re: s, im: c};
      default: w = '{re: c, im: s};
    endcase
    return w;
  endfunction

  task automatic shadow_write(input logic [9:0] adr, input logic [31:0] dat);
    if (adr < 10'd272) begin
      if (adr[0]) begin
        sh_im[adr[8:1]] = dat;
      end else begin
        sh_re[adr[8:1]] = dat;
      end
    end else if (adr >= 10'd512 && adr < 10'd576) begin
      sh_start[adr[5:0]] = dat[25:16];
      sh_step[adr[5:0]]  = dat[9:0];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One clock step at the falling edge
  ////////////////////////////////////////////////////////////

  task automatic tick();
    twiddle_t exp;
    int       cyc0;
    string    nm;
    logic     open;
    @(negedge clk);
    cycle++;
    i_start = 1'b0;
    i_valid = 1'b0;
    i_last  = 1'b0;
    if (o_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("o_valid went high with no sample in flight");
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp  = exp_q.pop_front();
        cyc0 = cyc_q.pop_front();
        nm   = name_q.pop_front();
        check_word({nm, " latency"}, 64'(cyc0 + 4), 64'(cycle));
        check_word(nm, exp, twiddle);
      end
    end else if (cyc_q.size() != 0 && cycle > cyc_q[0] + 4) begin
      $display("o_valid never came for the sample of %s", name_q[0]);
      errors++;
      exp  = exp_q.pop_front();
      cyc0 = cyc_q.pop_front();
      nm   = name_q.pop_front();
    end
    // Stb drops one clock after ack is seen
    if (bus_busy && ack_hold) begin
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      bus_busy   = 1'b0;
      ack_hold   = 1'b0;
    end else if (bus_busy && wb_rsp.ack) begin
      ack_hold  = 1'b1;
      bus_rdata = wb_rsp.dat;
      open      = started && !(last_sent && exp_q.size() == 0);
      assert (!open) else begin
        $display("Bus access was acked while a stream was still running");
        errors++;
      end
      if (wb_req.we) begin
        shadow_write(wb_req.adr, wb_req.dat);
      end
    end
  endtask

  task automatic issue_bus(input logic we, input logic [31:0] adr, input logic [31:0] dat);
    wb_req   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr[9:0], dat: dat};
    bus_busy = 1'b1;
    ack_hold = 1'b0;
  endtask

  task automatic wait_bus();
    int n;
    n = 0;
    while (bus_busy && !aborted) begin
      tick();
      n++;
      if (n > 200) begin
        $display("Timeout: bus cycle at address %h was never acked", wb_req.adr);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && !aborted) begin
      tick();
      n++;
      if (n > 200) begin
        $display("Timeout: stream samples still in flight");
        aborted = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Vector file player
  ////////////////////////////////////////////////////////////

  initial begin
    int                        fd;
    int                        line_no;
    string                     line;
    string                     nm;
    byte                       cmd;
    logic [31:0]               f1;
    logic [31:0]               f2;
    logic [31:0]               f3;
    twiddle_t                  model;
    logic [`PG_PHASE_BITS-1:0] phase_m;
    logic [`PG_PHASE_BITS-1:0] start_m;
    logic [`PG_PHASE_BITS-1:0] step_m;
    clk = 1'b0;
    rst_n = 1'b0;
    wb_req = '0;
    i_start = 1'b0;
    i_valid = 1'b0;
    i_last = 1'b0;
    entry_sel = '0;
    cycle = 0;
    errors = 0;
    checks = 0;
    aborted = 1'b0;
    bus_busy = 1'b0;
    ack_hold = 1'b0;
    bus_rdata = '0;
    started = 1'b0;
    last_sent = 1'b0;
    phase_m = '0;
    start_m = '0;
    step_m = '0;
    line_no = 0;
    for (int i = 0; i < `PG_TABLE_DEPTH; i++) begin
      sh_re[i] = '0;
      sh_im[i] = '0;
    end
    for (int i = 0; i < `PG_ENTRY_COUNT; i++) begin
      sh_start[i] = '0;
      sh_step[i]  = '0;
    end
    repeat (4) tick();
    rst_n = 1'b1;
    fd = $fopen("verif/pg_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      aborted = 1'b1;
    end
    while (!aborted && $fgets(line, fd) > 0) begin
      line_no++;
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      f1 = '0;
      f2 = '0;
      f3 = '0;
      void'($sscanf(line, "%c %h %h %h", cmd, f1, f2, f3));
      nm = $sformatf("vector line %0d", line_no);
      tick();
      case (cmd)
        "W": begin
          issue_bus(1'b1, f1, f2);
          wait_bus();
        end
        "R": begin
          issue_bus(1'b0, f1, '0);
          wait_bus();
          check_word(nm, 64'(f2), 64'(bus_rdata));
        end
        "P": issue_bus(1'b1, f1, f2);
        "Q": wait_bus();
        "S": begin
          entry_sel = f1[5:0];
          i_start   = 1'b1;
          start_m   = sh_start[f1[5:0]];
          step_m    = sh_step[f1[5:0]];
          phase_m   = start_m;
          started   = 1'b1;
          last_sent = 1'b0;
        end
        "V": begin
          model = octant_rule(phase_m);
          check_word({nm, " cross-check"}, {f2, f3}, model);
          i_valid = 1'b1;
          i_last  = f1[0];
          exp_q.push_back({f2, f3});
          cyc_q.push_back(cycle);
          name_q.push_back(nm);
          started   = 1'b1;
          last_sent = f1[0];
          phase_m   = f1[0] ? start_m : phase_m + step_m;
        end
        "I": repeat (f1) tick();
        "D": wait_drain();
        default: begin
          $display("Unknown command in %s", nm);
          errors++;
        end
      endcase
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    wait_drain();
    wait_bus();
    $display("Checks: %0d, errors: %0d, aborted: %0d", checks, errors, aborted);
    if (errors == 0 && !aborted) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verif/pg_vectors.txt
# cmd fields in hex: W adr dat | R adr expect | P adr dat posted | Q wait posted
# S entry | V last re im | I idle cycles | D wait for drain
W 000 00001000
W 001 00002000
W 002 00001001
W 003 00002001
W 100 00001080
W 101 00002080
W 200 00000080
W 201 03ff0001
W 3ff 12345678
R 001 00002000
R 101 00002080
R 201 03ff0001
R 3ff 00000000
R 300 00000000
S 00
V 0 00001000 ffffe000
V 0 00002080 ffffef80
V 0 ffffe000 fffff000
V 0 ffffef80 ffffdf80
V 0 fffff000 00002000
V 0 ffffdf80 00001080
V 0 00002000 00001000
V 0 00001080 00002080
V 1 00001000 ffffe000
D
V 1 00001000 ffffe000
S 01
V 0 00001001 00002001
I 3
V 0 00001000 ffffe000
I 1
V 1 00001001 ffffdfff
S 00
V 0 00001000 ffffe000
P 000 00001111
V 0 00002080 ffffef80
V 1 ffffe000 fffff000
Q
R 000 00001111
S 00
V 1 00001111 ffffe000
D

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_pg_top -o tb_pg_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_pg_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

// File: all.f
+incdir+common
common/pg_stream_pkg.sv
common/pg_bus_pkg.sv
rtl/pg_wb_slave.sv
phase_gen/pg_phase_accum.sv
phase_gen/pg_octant_fold.sv
phase_gen/pg_twiddle_ram.sv
phase_gen/pg_octant_unfold.sv
rtl/pg_top.sv
verif/tb_pg_top.sv
